// ==== hdl/trdb_macros.svh ====
// Widths of the trace encoder; FIFO depth must be a power of two, addresses are fixed at XLEN
`ifndef TRDB_MACROS_SVH
`define TRDB_MACROS_SVH

// Instruction address width
`define TRDB_XLEN 32

// Privilege level width
`define TRDB_PRIVLEN 3

// Exception cause width
`define TRDB_CAUSELEN 5

// Raw packet word, wide enough for the longest packet
`define TRDB_PACKET_LEN 80

// Packet length field in bits
`define TRDB_HEADER_LEN 7

// Packets buffered towards the sink
`define TRDB_FIFO_DEPTH 4

`endif

// ==== hdl/trdb_pkg.sv ====
// Trace encoder types; F_BRANCH_DIFF and SF_CONTEXT are encoded but never produced
`default_nettype none

`include "trdb_macros.svh"

package trdb_pkg;

    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd0,
        F_BRANCH_DIFF = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_t;

    typedef enum logic [1:0] {
        SF_START     = 2'd0,
        SF_EXCEPTION = 2'd1,
        SF_CONTEXT   = 2'd2,
        SF_UNDEF     = 2'd3
    } trdb_subformat_t;

    typedef logic [`TRDB_HEADER_LEN-1:0] trdb_len_t;

    // One retired instruction as reported by the core
    typedef struct packed {
        logic                      valid;
        logic [`TRDB_XLEN-1:0]     iaddr;
        logic [`TRDB_PRIVLEN-1:0]  priv;
        logic                      is_branch;
        logic                      branch_taken;
        logic                      exception;
        logic                      interrupt;
        logic [`TRDB_CAUSELEN-1:0] cause;
        logic                      discontinuity;
    } trdb_instr_t;

    // Packet order from the selector to the emitter
    typedef struct packed {
        logic                      valid;
        trdb_format_t              format;
        trdb_subformat_t           subformat;
        logic [`TRDB_XLEN-1:0]     iaddr;
        logic [`TRDB_PRIVLEN-1:0]  priv;
        logic                      is_branch;
        logic                      interrupt;
        logic [`TRDB_CAUSELEN-1:0] cause;
        logic [30:0]               branch_map;
        logic [4:0]                branch_cnt;
        logic                      map_full;
    } trdb_request_t;

    // Fields are listed MSB first, so the format sits in the two LSBs
    typedef struct packed {
        logic [`TRDB_PACKET_LEN-8:0] payload;
        logic [4:0]                  count;
        trdb_format_t                format;
    } trdb_branch_pkt_t;

    typedef struct packed {
        logic [`TRDB_PACKET_LEN-6-`TRDB_PRIVLEN-`TRDB_XLEN-`TRDB_CAUSELEN-1:0] pad;
        logic                      interrupt;
        logic [`TRDB_CAUSELEN-1:0] cause;
        logic [`TRDB_XLEN-1:0]     iaddr;
        logic                      is_branch;
        logic [`TRDB_PRIVLEN-1:0]  priv;
        trdb_subformat_t           subformat;
        trdb_format_t              format;
    } trdb_sync_pkt_t;

    typedef union packed {
        trdb_branch_pkt_t branch;
        trdb_sync_pkt_t   sync;
    } trdb_packet_u;

    typedef struct packed {
        trdb_packet_u bits;
        trdb_len_t    len;
    } trdb_entry_t;

    typedef struct packed {
        logic clear_overflow;
        logic enable;
    } trdb_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/trdb_ctrl_regs.sv ====
// Control registers; status_o[0] is enable, status_o[1] the sticky overflow, a drop beats a clear
`default_nettype none

module trdb_ctrl_regs (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                cfg_we_i,
    input  trdb_pkg::trdb_cfg_t cfg_wdata_i,
    input  logic                drop_i,
    output logic                enable_o,
    output logic [1:0]          status_o
);

    logic enable_q;
    logic overflow_q;
    logic overflow_d;

    // Overflow stays set until software clears it
    always_comb begin
        overflow_d = overflow_q;
        if (cfg_we_i && cfg_wdata_i.clear_overflow) begin
            overflow_d = 1'b0;
        end
        if (drop_i) begin
            overflow_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q   <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            if (cfg_we_i) begin
                enable_q <= cfg_wdata_i.enable;
            end
            overflow_q <= overflow_d;
        end
    end

    assign enable_o = enable_q;
    assign status_o = {overflow_q, enable_q};

endmodule

`default_nettype wire

// ==== hdl/trdb_packet_select.sv ====
// Packet selector; branch map holds at most 31 outcomes, disabling trace drops the map and restarts
`default_nettype none

module trdb_packet_select (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    enable_i,
    input  trdb_pkg::trdb_instr_t   instr_i,
    output trdb_pkg::trdb_request_t request_o
);
    import trdb_pkg::*;

    logic [30:0]     map_q;
    logic [30:0]     map_d;
    logic [4:0]      cnt_q;
    logic [4:0]      cnt_d;
    logic            started_q;
    logic            started_d;

    // Map and count with the current branch already appended
    logic [30:0]     map_app;
    logic [4:0]      cnt_app;

    logic            fire;
    trdb_format_t    fmt;
    trdb_subformat_t subfmt;
    logic            map_full;

    trdb_request_t   req_d;
    trdb_request_t   req_q;
    logic            req_valid_q;

    // Count never exceeds 30 here since a full map always triggers a packet
    always_comb begin
        map_app = map_q;
        cnt_app = cnt_q;
        if (instr_i.is_branch) begin
            map_app[cnt_q] = instr_i.branch_taken;
            cnt_app        = cnt_q + 5'd1;
        end
    end

    // Format priority: start, exception, discontinuity, full map
    always_comb begin
        fire     = 1'b0;
        fmt      = F_BRANCH_FULL;
        subfmt   = SF_START;
        map_full = 1'b0;
        if (enable_i && instr_i.valid) begin
            if (!started_q) begin
                fire   = 1'b1;
                fmt    = F_SYNC;
                subfmt = SF_START;
            end else if (instr_i.exception) begin
                fire   = 1'b1;
                fmt    = F_SYNC;
                subfmt = SF_EXCEPTION;
            end else if (instr_i.discontinuity) begin
                fire = 1'b1;
                fmt  = (cnt_app != 5'd0) ? F_BRANCH_FULL : F_ADDR_ONLY;
            end else if (cnt_app == 5'd31) begin
                fire     = 1'b1;
                fmt      = F_BRANCH_FULL;
                map_full = 1'b1;
            end
        end
    end

    always_comb begin
        started_d = started_q;
        map_d     = map_q;
        cnt_d     = cnt_q;
        if (!enable_i) begin
            started_d = 1'b0;
            map_d     = '0;
            cnt_d     = '0;
        end else if (instr_i.valid) begin
            started_d = 1'b1;
            // Every packet empties the map
            map_d     = fire ? '0 : map_app;
            cnt_d     = fire ? '0 : cnt_app;
        end
    end

    always_comb begin
        req_d.valid      = fire;
        req_d.format     = fmt;
        req_d.subformat  = subfmt;
        req_d.iaddr      = instr_i.iaddr;
        req_d.priv       = instr_i.priv;
        req_d.is_branch  = instr_i.is_branch;
        req_d.interrupt  = instr_i.interrupt;
        req_d.cause      = instr_i.cause;
        req_d.branch_map = map_app;
        req_d.branch_cnt = cnt_app;
        req_d.map_full   = map_full;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            started_q   <= 1'b0;
            map_q       <= '0;
            cnt_q       <= '0;
            req_valid_q <= 1'b0;
        end else begin
            started_q   <= started_d;
            map_q       <= map_d;
            cnt_q       <= cnt_d;
            req_valid_q <= fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            req_q <= req_d;
        end
    end

    always_comb begin
        request_o       = req_q;
        request_o.valid = req_valid_q;
    end

endmodule

`default_nettype wire

// ==== hdl/trdb_packet_emitter.sv ====
// Packet layout; purely combinational, F_BRANCH_DIFF gives an all-zero entry
`default_nettype none

`include "trdb_macros.svh"

module trdb_packet_emitter (
    input  trdb_pkg::trdb_request_t request_i,
    output trdb_pkg::trdb_entry_t   entry_o,
    output logic                    entry_valid_o
);
    import trdb_pkg::*;

    trdb_packet_u pkt;
    trdb_len_t    len;
    logic [5:0]   field_w;

    // Branch field sizes the decoder understands
    function automatic logic [5:0] round_field(input logic [4:0] cnt);
        if (cnt <= 5'd1) begin
            return 6'd1;
        end else if (cnt <= 5'd9) begin
            return 6'd9;
        end else if (cnt <= 5'd17) begin
            return 6'd17;
        end else if (cnt <= 5'd25) begin
            return 6'd25;
        end
        return 6'd31;
    endfunction

    assign field_w = round_field(request_i.branch_cnt);

    always_comb begin
        pkt = '0;
        len = '0;
        case (request_i.format)
            F_BRANCH_FULL: begin
                pkt.branch.format = F_BRANCH_FULL;
                pkt.branch.count  = request_i.branch_cnt;
                if (request_i.map_full) begin
                    // Full map without an address
                    pkt.branch.payload[30:0] = request_i.branch_map;
                    len = trdb_len_t'(9 + 31);
                end else begin
                    // Branch bits first, address right above them
                    case (field_w)
                        6'd1: pkt.branch.payload[0 +: 1 + `TRDB_XLEN] =
                            {request_i.iaddr, request_i.branch_map[0]};
                        6'd9: pkt.branch.payload[0 +: 9 + `TRDB_XLEN] =
                            {request_i.iaddr, request_i.branch_map[8:0]};
                        6'd17: pkt.branch.payload[0 +: 17 + `TRDB_XLEN] =
                            {request_i.iaddr, request_i.branch_map[16:0]};
                        6'd25: pkt.branch.payload[0 +: 25 + `TRDB_XLEN] =
                            {request_i.iaddr, request_i.branch_map[24:0]};
                        default: pkt.branch.payload[0 +: 31 + `TRDB_XLEN] =
                            {request_i.iaddr, request_i.branch_map};
                    endcase
                    len = trdb_len_t'(9 + field_w + `TRDB_XLEN);
                end
            end
            F_ADDR_ONLY: begin
                // No count field, the address follows the format directly
                pkt.branch.format = F_ADDR_ONLY;
                pkt[2 +: `TRDB_XLEN] = request_i.iaddr;
                len = trdb_len_t'(2 + `TRDB_XLEN);
            end
            F_SYNC: begin
                pkt.sync.format    = F_SYNC;
                pkt.sync.subformat = request_i.subformat;
                pkt.sync.priv      = request_i.priv;
                pkt.sync.is_branch = request_i.is_branch;
                pkt.sync.iaddr     = request_i.iaddr;
                len = trdb_len_t'(4 + `TRDB_PRIVLEN + 1 + `TRDB_XLEN);
                if (request_i.subformat == SF_EXCEPTION) begin
                    pkt.sync.cause     = request_i.cause;
                    pkt.sync.interrupt = request_i.interrupt;
                    len = trdb_len_t'(4 + `TRDB_PRIVLEN + 1 + `TRDB_XLEN + `TRDB_CAUSELEN + 1);
                end
            end
            default: begin
                // Differential branch packets are not generated
                pkt = '0;
            end
        endcase
    end

    assign entry_o.bits  = pkt;
    assign entry_o.len   = len;
    assign entry_valid_o = request_i.valid;

endmodule

`default_nettype wire

// ==== hdl/trdb_packet_fifo.sv ====
// Packet FIFO; depth must be a power of two, a write into a full FIFO without a read is dropped
`default_nettype none

`include "trdb_macros.svh"

module trdb_packet_fifo (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  trdb_pkg::trdb_entry_t data_i,
    input  logic                  valid_i,
    output logic                  drop_o,
    output trdb_pkg::trdb_entry_t data_o,
    output logic                  valid_o,
    input  logic                  grant_i
);
    import trdb_pkg::*;

    localparam int unsigned AW = $clog2(`TRDB_FIFO_DEPTH);

    trdb_entry_t mem [`TRDB_FIFO_DEPTH];

    // One extra pointer bit tells full from empty
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;
    logic        empty;
    logic        full;
    logic        push;
    logic        pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign pop  = !empty && grant_i;
    assign push = valid_i && (!full || pop);

    assign drop_o  = valid_i && full && !pop;
    assign valid_o = !empty;
    assign data_o  = mem[rd_ptr_q[AW-1:0]];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q[AW-1:0]] <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/trdb_top.sv ====
// Trace encoder top; packets appear two cycles after their instruction when the FIFO is empty
`default_nettype none

module trdb_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  trdb_pkg::trdb_instr_t instr_i,
    input  logic                  cfg_we_i,
    input  trdb_pkg::trdb_cfg_t   cfg_wdata_i,
    output logic [1:0]            status_o,
    output trdb_pkg::trdb_entry_t packet_o,
    output logic                  packet_valid_o,
    input  logic                  packet_grant_i
);
    import trdb_pkg::*;

    logic          enable;
    logic          drop;
    trdb_request_t request;
    trdb_entry_t   entry;
    logic          entry_valid;

    trdb_ctrl_regs i_ctrl_regs (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cfg_we_i    (cfg_we_i),
        .cfg_wdata_i (cfg_wdata_i),
        .drop_i      (drop),
        .enable_o    (enable),
        .status_o    (status_o)
    );

    trdb_packet_select i_packet_select (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .enable_i  (enable),
        .instr_i   (instr_i),
        .request_o (request)
    );

    trdb_packet_emitter i_packet_emitter (
        .request_i     (request),
        .entry_o       (entry),
        .entry_valid_o (entry_valid)
    );

    // Packets wait here until the sink grants them
    trdb_packet_fifo i_packet_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .data_i  (entry),
        .valid_i (entry_valid),
        .drop_o  (drop),
        .data_o  (packet_o),
        .valid_o (packet_valid_o),
        .grant_i (packet_grant_i)
    );

endmodule

`default_nettype wire

// ==== dv/trdb_tb.sv ====
// Testbench for trdb_top; compares every packet with a behavioral model, FIFO depth must be 2 or more
`default_nettype none

`include "trdb_macros.svh"

module trdb_tb;
    import trdb_pkg::*;

    localparam int PL        = `TRDB_PACKET_LEN;
    localparam int EW        = `TRDB_PACKET_LEN + `TRDB_HEADER_LEN;
    localparam int DEPTH     = `TRDB_FIFO_DEPTH;
    localparam int ADDR_LSB  = 4 + `TRDB_PRIVLEN + 1;
    localparam int CAUSE_LSB = ADDR_LSB + `TRDB_XLEN;
    localparam int IRQ_LSB   = CAUSE_LSB + `TRDB_CAUSELEN;
    localparam int LIMIT     = 400;

    logic          clk = 1'b0;
    logic          rst_n = 1'b0;
    trdb_instr_t   instr = '0;
    logic          cfg_we = 1'b0;
    trdb_cfg_t     cfg_wdata = '0;
    logic [1:0]    status;
    trdb_entry_t   packet;
    logic          packet_valid;
    logic          packet_grant = 1'b0;
    logic [EW-1:0] packet_bits;

    // Model state mirrors the packet rules
    bit            m_en;
    bit            m_started;
    logic [30:0]   m_map = '0;
    int            m_cnt;
    logic [EW-1:0] exp_q[$];
    logic [EW-1:0] exp_word;
    bit            sink_stalled;
    int            grant_mode;
    logic [31:0]   stim_seed = 32'd53205;
    logic [31:0]   grant_seed = 32'd53205;
    trdb_instr_t   ins;
    logic [31:0]   r;
    int            k;
    int            t;
    int            lat;

    trdb_top trdb_top_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .instr_i        (instr),
        .cfg_we_i       (cfg_we),
        .cfg_wdata_i    (cfg_wdata),
        .status_o       (status),
        .packet_o       (packet),
        .packet_valid_o (packet_valid),
        .packet_grant_i (packet_grant)
    );

    assign packet_bits = packet;

    always #2 clk = ~clk;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after the first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    function automatic trdb_instr_t plain_instr(input logic [31:0] addr);
        trdb_instr_t i;
        i       = '0;
        i.valid = 1'b1;
        i.iaddr = addr;
        i.priv  = 3'd3;
        return i;
    endfunction

    function automatic trdb_instr_t random_instr();
        logic [31:0] v;
        trdb_instr_t i;
        v               = next_rand();
        i               = '0;
        i.valid         = 1'b1;
        i.iaddr         = next_rand();
        i.priv          = v[31 -: `TRDB_PRIVLEN];
        i.is_branch     = v[28];
        i.branch_taken  = v[27];
        i.exception     = (v[26:23] == 4'd0);
        i.interrupt     = v[22];
        i.cause         = v[21 -: `TRDB_CAUSELEN];
        i.discontinuity = (v[16:14] == 3'd0);
        return i;
    endfunction

    // Sync layout from the LSB: format, subformat, priv, is_branch, address, cause, interrupt
    function automatic logic [PL-1:0] sync_bits(input trdb_instr_t i, input bit exc);
        logic [PL-1:0] b;
        b = PL'(3) | (PL'(exc) << 2) | (PL'(i.priv) << 4);
        b = b | (PL'(i.is_branch) << (4 + `TRDB_PRIVLEN)) | (PL'(i.iaddr) << ADDR_LSB);
        if (exc) begin
            b = b | (PL'(i.cause) << CAUSE_LSB) | (PL'(i.interrupt) << IRQ_LSB);
        end
        return b;
    endfunction

    function automatic void model_step(input trdb_instr_t i);
        logic [PL-1:0] b;
        int            len;
        int            w;
        bit            fire;
        b    = '0;
        len  = 0;
        w    = 0;
        fire = 1'b1;
        if (!m_en || !i.valid) begin
            return;
        end
        if (i.is_branch) begin
            m_map[m_cnt] = i.branch_taken;
            m_cnt++;
        end
        if (!m_started) begin
            b   = sync_bits(i, 1'b0);
            len = ADDR_LSB + `TRDB_XLEN;
        end else if (i.exception) begin
            b   = sync_bits(i, 1'b1);
            len = ADDR_LSB + `TRDB_XLEN + `TRDB_CAUSELEN + 1;
        end else if (i.discontinuity && m_cnt == 0) begin
            b   = PL'(2) | (PL'(i.iaddr) << 2);
            len = 2 + `TRDB_XLEN;
        end else if (i.discontinuity) begin
            w   = (m_cnt <= 1) ? 1 : (m_cnt <= 9) ? 9 : (m_cnt <= 17) ? 17 : (m_cnt <= 25) ? 25 : 31;
            b   = PL'(m_cnt) << 2;
            b   = b | ((PL'(m_map) & ((PL'(1) << w) - PL'(1))) << 7);
            b   = b | (PL'(i.iaddr) << (7 + w));
            len = 9 + w + `TRDB_XLEN;
        end else if (m_cnt == 31) begin
            b   = (PL'(31) << 2) | (PL'(m_map) << 7);
            len = 9 + 31;
        end else begin
            fire = 1'b0;
        end
        m_started = 1'b1;
        if (fire) begin
            m_map = '0;
            m_cnt = 0;
            // A stalled sink with a full FIFO loses the packet
            if (!(sink_stalled && exp_q.size() >= DEPTH)) begin
                exp_q.push_back({b, len[`TRDB_HEADER_LEN-1:0]});
            end
        end
    endfunction

    task automatic write_cfg(input logic en, input logic clr);
        @(posedge clk);
        cfg_we                   <= 1'b1;
        cfg_wdata.enable         <= en;
        cfg_wdata.clear_overflow <= clr;
        @(posedge clk);
        cfg_we <= 1'b0;
        if (!en) begin
            m_started = 1'b0;
            m_map     = '0;
            m_cnt     = 0;
        end
        m_en = en;
    endtask

    // With gate set, hold the instruction back until the FIFO cannot overflow
    task automatic send_instr(input trdb_instr_t i, input bit gate);
        int n;
        n = 0;
        @(negedge clk);
        while (gate && exp_q.size() >= DEPTH && n < LIMIT) begin
            @(posedge clk);
            instr <= '0;
            @(negedge clk);
            n++;
        end
        assert (n < LIMIT) else stop_run("Timed out waiting for room in the packet FIFO");
        @(posedge clk);
        instr <= i;
        model_step(i);
    endtask

    task automatic idle();
        @(posedge clk);
        instr <= '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || packet_valid) && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (n < LIMIT) else stop_run("Timed out waiting for the expected packets to drain");
    endtask

    always @(posedge clk) begin
        if (!rst_n || grant_mode == 1) begin
            packet_grant <= 1'b0;
        end else if (grant_mode == 0) begin
            packet_grant <= 1'b1;
        end else begin
            grant_seed = lcg_next(grant_seed);
            packet_grant <= (grant_seed[31:30] != 2'd0);
        end
    end

    // Output check at every handshake
    always @(posedge clk) begin
        if (rst_n && packet_valid && packet_grant) begin
            assert (exp_q.size() != 0) else stop_run("A packet came out while none was expected");
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                assert (packet_bits == exp_word)
                    else stop_run($sformatf("[FAIL] t=%0t packet %h len %0d, expected %h len %0d",
                        $time, packet_bits[EW-1:`TRDB_HEADER_LEN],
                        packet_bits[`TRDB_HEADER_LEN-1:0], exp_word[EW-1:`TRDB_HEADER_LEN],
                        exp_word[`TRDB_HEADER_LEN-1:0]));
            end
        end
    end

    hold_until_grant: assert property (@(posedge clk) disable iff (!rst_n)
        (packet_valid && !packet_grant) |=> (packet_valid && $stable(packet_bits)))
        else stop_run("Packet output changed or vanished before it was granted");

    initial begin
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!packet_valid && status == 2'b00)
            else stop_run($sformatf("[FAIL] t=%0t outputs not idle after reset", $time));
        write_cfg(1'b1, 1'b0);
        @(negedge clk);
        assert (status == 2'b01)
            else stop_run($sformatf("[FAIL] t=%0t status %b after enable", $time, status));

        // First instruction gives sync start two cycles later
        send_instr(plain_instr(32'h8000_0100), 1'b1);
        @(posedge clk);
        instr <= '0;
        lat = 1;
        @(negedge clk);
        while (!packet_valid && lat < 10) begin
            lat++;
            @(negedge clk);
        end
        assert (packet_valid) else stop_run("Timed out waiting for the sync start packet");
        assert (lat == 2)
            else stop_run($sformatf("[FAIL] t=%0t packet latency %0d cycles", $time, lat));
        wait_drain();

        // Full branch map
        for (int i = 0; i < 31; i++) begin
            ins           = plain_instr(32'h0000_1000 + 32'(4 * i));
            r             = next_rand();
            ins.is_branch = 1'b1;
            ins.branch_taken = r[31];
            send_instr(ins, 1'b1);
        end
        idle();
        wait_drain();

        // Discontinuity after k branches, k of zero first
        for (int round = 0; round < 8; round++) begin
            r = next_rand();
            k = (round == 0) ? 0 : int'(r % 32'd31);
            for (int j = 0; j < k; j++) begin
                ins = random_instr();
                ins.is_branch     = 1'b1;
                ins.exception     = 1'b0;
                ins.discontinuity = 1'b0;
                send_instr(ins, 1'b1);
            end
            ins = random_instr();
            ins.is_branch     = 1'b0;
            ins.exception     = 1'b0;
            ins.discontinuity = 1'b1;
            send_instr(ins, 1'b1);
        end
        idle();
        wait_drain();

        // Exception wins over a discontinuity in the same instruction
        for (int j = 0; j < 3; j++) begin
            ins = plain_instr(32'h0000_2000 + 32'(4 * j));
            ins.is_branch = 1'b1;
            send_instr(ins, 1'b1);
        end
        ins               = random_instr();
        ins.exception     = 1'b1;
        ins.discontinuity = 1'b1;
        send_instr(ins, 1'b1);
        idle();
        wait_drain();

        // Sink stalled, two packets beyond the depth get lost
        grant_mode   = 1;
        sink_stalled = 1'b1;
        for (int j = 0; j < DEPTH + 2; j++) begin
            ins = plain_instr(32'h0000_3000 + 32'(16 * j));
            ins.discontinuity = 1'b1;
            send_instr(ins, 1'b0);
        end
        idle();
        t = 0;
        while (!status[1] && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        assert (status[1]) else stop_run("Overflow flag never set while the sink was stalled");
        grant_mode   = 0;
        sink_stalled = 1'b0;
        wait_drain();
        write_cfg(1'b1, 1'b1);
        t = 0;
        @(negedge clk);
        while (status[1] && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        assert (status == 2'b01)
            else stop_run($sformatf("[FAIL] t=%0t status %b after overflow clear", $time, status));

        // Mixed stream with random grant gaps
        grant_mode = 2;
        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            if (r[31:29] == 3'd0) begin
                idle();
            end else begin
                send_instr(random_instr(), 1'b1);
            end
        end
        idle();
        wait_drain();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/trdb_pkg.sv
hdl/trdb_ctrl_regs.sv
hdl/trdb_packet_select.sv
hdl/trdb_packet_emitter.sv
hdl/trdb_packet_fifo.sv
hdl/trdb_top.sv
dv/trdb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches its output for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module trdb_tb -f all.f -Mdir obj_dir &&
./obj_dir/Vtrdb_tb | tee /dev/stderr | grep -qF "TEST RESULT: PASS" &&
echo "Simulation passed" ||
{
    echo "Simulation failed"
    exit 1
}
